/* list.f */
+incdir+verilog
verilog/tmu_pkg.sv
verilog/tmu_vdivops.sv
verilog/tmu_divider.sv
verilog/tmu_vdiv_ctrl.sv
verilog/tmu_vdiv.sv
tb/tmu_vdiv_checker.sv
tb/tb_tmu_vdiv.sv

/* tb/tb_tmu_vdiv.sv */
// testbench of the vertical division front end
// seeded random quads through the DUT, results checked by tmu_vdiv_checker
`default_nettype none
`include "tmu_defs.svh"

module tb_tmu_vdiv
	import tmu_pkg::*;
();

	localparam int XFER_LIMIT = 100; // cycles one handshake may take
	localparam int DRAIN_LIMIT = 5000; // cycles to empty the pipeline under back-pressure

	logic sys_clk = 1'b0;
	logic sys_rst = 1'b1;
	logic pipe_stb_i = 1'b0;
	vdiv_in_t in_i = '0;
	logic [`TMU_SQH_W-1:0] dst_squareh_i = 1;
	logic pipe_ack_i = 1'b1;
	logic pipe_ack_o, pipe_stb_o, busy_o;
	vdiv_out_t out_o;
	logic backpressure = 1'b0;
	logic ack_next;
	int errors, in_count, out_count;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start;
	string current_test;
	vdiv_in_t q;

	always #2 sys_clk = ~sys_clk;

	tmu_vdiv uut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.in_i(in_i),
		.dst_squareh_i(dst_squareh_i),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.out_o(out_o),
		.busy_o(busy_o)
	);

	tmu_vdiv_checker chk (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.in_stb_i(pipe_stb_i),
		.in_ack_i(pipe_ack_o),
		.in_i(in_i),
		.squareh_i(dst_squareh_i),
		.out_stb_i(pipe_stb_o),
		.out_ack_i(pipe_ack_i),
		.out_i(out_o),
		.busy_i(busy_o),
		.errors_o(errors),
		.in_count_o(in_count),
		.out_count_o(out_count)
	);

	// downstream stalls about a third of the cycles while back-pressure is on
	always @(posedge sys_clk) begin
		ack_next = !backpressure || ($urandom_range(2, 0) != 0);
		#1;
		pipe_ack_i = ack_next;
	end

	function automatic logic signed [`TMU_COORD_W-1:0] random_coord(input int span);
		return int'($urandom_range(2 * span, 0)) - span;
	endfunction

	// span 65535 keeps every edge magnitude inside TMU_DIFF_W bits
	function automatic vdiv_in_t random_quad(input int span);
		vdiv_in_t r;

		r.a.x = random_coord(span);
		r.a.y = random_coord(span);
		r.b.x = random_coord(65535);
		r.b.y = random_coord(65535);
		r.c.x = random_coord(span);
		r.c.y = random_coord(span);
		r.d.x = random_coord(span);
		r.d.y = random_coord(span);
		r.drx = `TMU_DR_W'($urandom);
		r.dry = `TMU_DR_W'($urandom);
		return r;
	endfunction

	task automatic print_summary();
		$display("tests run %0d, tests failed %0d, errors %0d, quads in %0d, results out %0d",
			tests_run, tests_failed, errors, in_count, out_count);
	endtask

	task automatic abort_run(input string msg);
		chk.report_problem(msg);
		print_summary();
		$display("TEST FAILED");
		$finish;
	endtask

	// called just after a rising edge, returns just after the accepting edge
	task automatic send_quad(input vdiv_in_t quad);
		int waited;

		waited = 0;
		in_i = quad;
		pipe_stb_i = 1'b1;
		@(negedge sys_clk);
		while (!pipe_ack_o) begin
			waited++;
			if (waited > XFER_LIMIT)
				abort_run("pipe_ack_o stayed low for a pending quad");
			@(negedge sys_clk);
		end
		@(posedge sys_clk);
		#1;
		pipe_stb_i = 1'b0;
	endtask

	// busy_o is looked at in the middle of the cycle and the task returns after a rising edge
	task automatic wait_drain();
		int waited;

		waited = 0;
		@(negedge sys_clk);
		while (busy_o) begin
			waited++;
			if (waited > DRAIN_LIMIT)
				abort_run("busy_o did not fall after the last quad");
			@(negedge sys_clk);
		end
		@(posedge sys_clk);
		#1;
	endtask

	task automatic start_test(input string name);
		current_test = name;
		chk.set_test(name);
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		wait_drain(); // every result of the test is compared before the verdict
		if (errors == errors_at_start) begin
			$display("test %s passed", current_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", current_test, errors - errors_at_start);
		end
	endtask

	initial begin
		void'($urandom(32'hd491));
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		start_test("reset_state");
		chk.check_reset_state();
		end_test();

		start_test("random_quads");
		dst_squareh_i = $urandom_range(2047, 1);
		repeat (20) send_quad(random_quad(65535)); // back to back, no stalls
		end_test();

		start_test("equal_and_reversed");
		dst_squareh_i = 1; // quotient then shows the magnitude itself
		repeat (6) begin
			q = random_quad(30000);
			q.c = q.a; // both c edges are zero
			q.d.x = q.a.x - `TMU_COORD_W'($urandom_range(30000, 1));
			q.d.y = q.a.y - `TMU_COORD_W'($urandom_range(30000, 1));
			send_quad(q);
		end
		q.a.x = 18'sd65535; // largest magnitude in both directions
		q.a.y = -18'sd65536;
		q.c.x = -18'sd65536;
		q.c.y = 18'sd65535;
		q.d = q.a;
		send_quad(q);
		end_test();

		start_test("backpressure");
		backpressure = 1'b1;
		repeat (30) send_quad(random_quad(65535));
		end_test();
		backpressure = 1'b0;

		start_test("zero_height");
		dst_squareh_i = '0;
		repeat (8) send_quad(random_quad(1000)); // magnitudes stay below 2048
		end_test();

		start_test("drain");
		wait_drain();
		chk.check_drained();
		end_test();

		print_summary();
		if (tests_failed == 0 && errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tmu_vdiv_checker.sv */
// scoreboard of the vertical division front end
// predicts every result from the quad and square height seen at the input transfer
// and compares the outputs in order, including stability under back-pressure
`default_nettype none
`include "tmu_defs.svh"

module tmu_vdiv_checker
	import tmu_pkg::*;
(
	input wire sys_clk,
	input wire sys_rst,
	input wire in_stb_i,
	input wire in_ack_i,
	input wire vdiv_in_t in_i,
	input wire [`TMU_SQH_W-1:0] squareh_i,
	input wire out_stb_i,
	input wire out_ack_i,
	input wire vdiv_out_t out_i,
	input wire busy_i,
	output int errors_o,
	output int in_count_o,
	output int out_count_o
);

	vdiv_out_t expected_q[$]; // predicted results of the quads still inside the DUT
	vdiv_out_t held; // output seen while the strobe waited for ack
	logic waiting = 1'b0;
	string test_name = "none";

	// one edge from vertex from to vertex to, divided by the square height
	function automatic quot_t divide_edge(input int from, input int to, input int sqh);
		quot_t res;
		int mag;

		res.positive = to > from; // equal coordinates are not positive
		mag = res.positive ? to - from : from - to;
		if (sqh == 0) begin
			res.quotient = '1;
			res.remainder = mag; // only the low bits of the magnitude fit
		end else begin
			res.quotient = mag / sqh;
			res.remainder = mag % sqh;
		end
		return res;
	endfunction

	function automatic vdiv_out_t predict(input vdiv_in_t q, input int sqh);
		vdiv_out_t r;

		r.a = q.a; // pass-through fields
		r.b = q.b;
		r.drx = q.drx;
		r.dry = q.dry;
		r.cx = divide_edge(q.a.x, q.c.x, sqh);
		r.cy = divide_edge(q.a.y, q.c.y, sqh);
		r.dx = divide_edge(q.a.x, q.d.x, sqh);
		r.dy = divide_edge(q.a.y, q.d.y, sqh);
		return r;
	endfunction

	task automatic compare_value(input string what, input logic [255:0] exp,
		input logic [255:0] act);
		if (exp !== act) begin
			errors_o++;
			$display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		errors_o++;
		$display("ERROR in %s: %s", test_name, msg);
	endtask

	task automatic set_test(input string name);
		test_name = name;
	endtask

	task automatic check_reset_state();
		compare_value("pipe_stb_o", 0, out_stb_i);
		compare_value("busy_o", 0, busy_i);
		compare_value("pipe_ack_o", 1, in_ack_i); // empty pipeline accepts at once
	endtask

	// after busy_o fell every quad that went in must have come out exactly once
	task automatic check_drained();
		compare_value("results out against quads in", in_count_o, out_count_o);
		compare_value("pending results", 0, expected_q.size());
	endtask

	// the testbench drives just after the rising edge so everything is settled here
	always @(negedge sys_clk) begin
		if (sys_rst) begin
			waiting = 1'b0;
		end else begin
			if (waiting && !out_stb_i)
				report_problem("pipe_stb_o fell before it was acknowledged");
			else if (waiting)
				compare_value("out_o held under back-pressure", held, out_i);
			if (in_stb_i && in_ack_i) begin // a quad enters on the next edge
				expected_q.push_back(predict(in_i, squareh_i));
				in_count_o++;
			end
			if (out_stb_i && out_ack_i) begin
				out_count_o++;
				if (expected_q.size() == 0)
					report_problem("result delivered with no quad pending");
				else
					compare_value($sformatf("out_o of result %0d", out_count_o),
						expected_q.pop_front(), out_i);
			end
			waiting = out_stb_i && !out_ack_i;
			held = out_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/tmu_vdiv.sv */
// vertical division front end of the texture mapping unit
// difference stage, then four edge dividers run by one control unit
// the square height must stay stable while busy is high
`default_nettype none
`include "tmu_defs.svh"

module tmu_vdiv
	import tmu_pkg::*;
(
	input wire sys_clk,
	input wire sys_rst,

	input wire pipe_stb_i,
	output logic pipe_ack_o,
	input wire vdiv_in_t in_i,
	input wire [`TMU_SQH_W-1:0] dst_squareh_i,

	output logic pipe_stb_o,
	input wire pipe_ack_i,
	output vdiv_out_t out_o,

	output logic busy_o
);

	logic ops_stb; // difference record waiting for the control unit
	logic ops_ack;
	vdiv_ops_t ops;
	logic div_load;
	logic div_step;
	logic ctrl_busy;
	quot_t [3:0] quot; // divider results in cx, cy, dx, dy order

	tmu_vdivops vdivops (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.in_i(in_i),
		.pipe_stb_o(ops_stb),
		.pipe_ack_i(ops_ack),
		.ops_o(ops)
	);

	tmu_vdiv_ctrl ctrl (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(ops_stb),
		.pipe_ack_o(ops_ack),
		.ops_i(ops),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.out_o(out_o),
		.busy_o(ctrl_busy),
		.div_load_o(div_load),
		.div_step_o(div_step),
		.quot_i(quot)
	);

	// signs are tracked by the control unit so the divider results carry none
	assign quot[0].positive = 1'b0;
	assign quot[1].positive = 1'b0;
	assign quot[2].positive = 1'b0;
	assign quot[3].positive = 1'b0;

	tmu_divider div_cx (
		.sys_clk(sys_clk),
		.load_i(div_load),
		.step_i(div_step),
		.dividend_i(ops.cx.mag),
		.divisor_i(dst_squareh_i),
		.quotient_o(quot[0].quotient),
		.remainder_o(quot[0].remainder)
	);

	tmu_divider div_cy (
		.sys_clk(sys_clk),
		.load_i(div_load),
		.step_i(div_step),
		.dividend_i(ops.cy.mag),
		.divisor_i(dst_squareh_i),
		.quotient_o(quot[1].quotient),
		.remainder_o(quot[1].remainder)
	);

	tmu_divider div_dx (
		.sys_clk(sys_clk),
		.load_i(div_load),
		.step_i(div_step),
		.dividend_i(ops.dx.mag),
		.divisor_i(dst_squareh_i),
		.quotient_o(quot[2].quotient),
		.remainder_o(quot[2].remainder)
	);

	tmu_divider div_dy (
		.sys_clk(sys_clk),
		.load_i(div_load),
		.step_i(div_step),
		.dividend_i(ops.dy.mag),
		.divisor_i(dst_squareh_i),
		.quotient_o(quot[3].quotient),
		.remainder_o(quot[3].remainder)
	);

	assign busy_o = ops_stb | ctrl_busy; // any record anywhere in the front end

endmodule

`default_nettype wire

/* verilog/tmu_vdiv_ctrl.sv */
// division control of the vertical front end
// takes one difference record at a time and runs the four dividers in lockstep
// then holds the assembled result until the next stage acknowledges it
`default_nettype none
`include "tmu_defs.svh"

module tmu_vdiv_ctrl
	import tmu_pkg::*;
(
	input wire sys_clk,
	input wire sys_rst,

	input wire pipe_stb_i,
	output logic pipe_ack_o,
	input wire vdiv_ops_t ops_i,

	output logic pipe_stb_o,
	input wire pipe_ack_i,
	output vdiv_out_t out_o,

	output logic busy_o,
	output logic div_load_o,
	output logic div_step_o,
	input wire quot_t [3:0] quot_i // cx, cy, dx, dy from index 0 up, sign bits unused
);

	localparam int CNT_W = $clog2(`TMU_DIFF_W + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_DIVIDING,
		S_FULL
	} state_t;

	state_t state;
	logic [CNT_W-1:0] step_cnt; // steps issued in the current division
	logic accept;
	logic last; // every step issued, the dividers hold their results

	assign pipe_ack_o = (state == S_IDLE); // one record in flight at most
	assign accept = pipe_stb_i & pipe_ack_o;
	assign last = (step_cnt == CNT_W'(`TMU_DIFF_W));

	assign div_load_o = accept; // dividers capture the magnitudes on the acceptance edge
	assign div_step_o = (state == S_DIVIDING) & ~last;
	assign pipe_stb_o = (state == S_FULL);
	assign busy_o = (state != S_IDLE);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			step_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (accept) begin
					state <= S_DIVIDING;
					step_cnt <= '0;
				end
				S_DIVIDING: begin
					step_cnt <= step_cnt + 1'b1;
					if (last)
						state <= S_FULL; // one cycle after the final step
				end
				S_FULL: if (pipe_ack_i)
					state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// output record is filled in two parts and then held while the strobe is up
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			out_o.a <= ops_i.a;
			out_o.b <= ops_i.b;
			out_o.drx <= ops_i.drx;
			out_o.dry <= ops_i.dry;
			out_o.cx.positive <= ops_i.cx.positive; // signs skip the dividers
			out_o.cy.positive <= ops_i.cy.positive;
			out_o.dx.positive <= ops_i.dx.positive;
			out_o.dy.positive <= ops_i.dy.positive;
		end
		if ((state == S_DIVIDING) && last) begin
			out_o.cx.quotient <= quot_i[0].quotient;
			out_o.cx.remainder <= quot_i[0].remainder;
			out_o.cy.quotient <= quot_i[1].quotient;
			out_o.cy.remainder <= quot_i[1].remainder;
			out_o.dx.quotient <= quot_i[2].quotient;
			out_o.dx.remainder <= quot_i[2].remainder;
			out_o.dy.quotient <= quot_i[3].quotient;
			out_o.dy.remainder <= quot_i[3].remainder;
		end
	end

endmodule

`default_nettype wire

/* verilog/tmu_divider.sv */
// iterative restoring divider for one edge magnitude
// one quotient bit per step, complete after as many steps as the dividend has bits
// a zero divisor gives an all ones quotient and the low bits of the dividend
`default_nettype none
`include "tmu_defs.svh"

module tmu_divider (
	input wire sys_clk,
	input wire load_i,
	input wire step_i,
	input wire [`TMU_DIFF_W-1:0] dividend_i,
	input wire [`TMU_SQH_W-1:0] divisor_i,
	output logic [`TMU_DIFF_W-1:0] quotient_o,
	output logic [`TMU_SQH_W-1:0] remainder_o
);

	logic [`TMU_DIFF_W-1:0] shreg; // dividend bits shift out at the top, quotient bits in below
	logic [`TMU_SQH_W-1:0] prem; // partial remainder, always below the divisor
	logic [`TMU_SQH_W:0] trial; // partial remainder with the next dividend bit appended
	logic fits;

	assign trial = {prem, shreg[`TMU_DIFF_W-1]};
	assign fits = trial >= {1'b0, divisor_i}; // divisor zero always fits

	// load starts a new division and every step adds one quotient bit
	always_ff @(posedge sys_clk) begin
		if (load_i) begin
			shreg <= dividend_i;
			prem <= '0;
		end else if (step_i) begin
			if (fits) begin
				prem <= trial[`TMU_SQH_W-1:0] - divisor_i; // result is below the divisor
				shreg <= {shreg[`TMU_DIFF_W-2:0], 1'b1};
			end else begin
				// trial is below the divisor here so the top bit is clear
				prem <= trial[`TMU_SQH_W-1:0];
				shreg <= {shreg[`TMU_DIFF_W-2:0], 1'b0};
			end
		end
	end

	assign quotient_o = shreg; // valid once all steps are done
	assign remainder_o = prem;

endmodule

`default_nettype wire

/* verilog/tmu_vdivops.sv */
// vertical difference stage of the texture mapping front end
// computes the edges c-a and d-a per axis as sign and magnitude
// a, b and the destination resolution are registered unchanged
// one record deep, with the usual strobe/acknowledge handshake on both sides
`default_nettype none
`include "tmu_defs.svh"

module tmu_vdivops
	import tmu_pkg::*;
(
	input wire sys_clk,
	input wire sys_rst,

	input wire pipe_stb_i,
	output logic pipe_ack_o,
	input wire vdiv_in_t in_i,

	output logic pipe_stb_o,
	input wire pipe_ack_i,
	output vdiv_ops_t ops_o
);

	logic xfer_in; // a quad is taken on this edge

	// sign and magnitude of the difference to minus from
	function automatic diff_t edge_diff(
		input logic signed [`TMU_COORD_W-1:0] from,
		input logic signed [`TMU_COORD_W-1:0] to
	);
		diff_t res;
		logic signed [`TMU_COORD_W-1:0] delta;

		res.positive = to > from; // equal coordinates count as not positive
		delta = res.positive ? to - from : from - to;
		res.mag = delta[`TMU_DIFF_W-1:0]; // magnitudes fit in the narrower field
		return res;
	endfunction

	// accept when empty or when the held record leaves in this same cycle
	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign xfer_in = pipe_stb_i & pipe_ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
		end else if (xfer_in) begin
			pipe_stb_o <= 1'b1; // new record valid from the next cycle
		end else if (pipe_ack_i) begin
			pipe_stb_o <= 1'b0; // record taken and nothing new arrived
		end
	end

	// payload only moves on an input transfer so it holds under back-pressure
	always_ff @(posedge sys_clk) begin
		if (xfer_in) begin
			ops_o.cx <= edge_diff(in_i.a.x, in_i.c.x);
			ops_o.cy <= edge_diff(in_i.a.y, in_i.c.y);
			ops_o.dx <= edge_diff(in_i.a.x, in_i.d.x);
			ops_o.dy <= edge_diff(in_i.a.y, in_i.d.y);

			// pass-through fields for the later stages
			ops_o.a <= in_i.a;
			ops_o.b <= in_i.b;
			ops_o.drx <= in_i.drx;
			ops_o.dry <= in_i.dry;
		end
	end

endmodule

`default_nettype wire

/* verilog/tmu_pkg.sv */
// shared types of the vertical division front end
// vertex sets and stage results travel between the stages as packed structs
`default_nettype none
`include "tmu_defs.svh"

package tmu_pkg;

	// one mesh vertex
	typedef struct packed {
		logic signed [`TMU_COORD_W-1:0] x;
		logic signed [`TMU_COORD_W-1:0] y;
	} point_t;

	// quad as it enters the difference stage
	typedef struct packed {
		point_t a;
		point_t b;
		point_t c; // c and d are the lower vertices of the vertical edges
		point_t d;
		logic signed [`TMU_DR_W-1:0] drx;
		logic signed [`TMU_DR_W-1:0] dry;
	} vdiv_in_t;

	// edge difference split into sign and magnitude
	typedef struct packed {
		logic positive; // set only when the end coordinate is strictly greater
		logic [`TMU_DIFF_W-1:0] mag;
	} diff_t;

	// record between the difference stage and the division control
	typedef struct packed {
		point_t a;
		point_t b;
		diff_t cx;
		diff_t cy;
		diff_t dx;
		diff_t dy;
		logic signed [`TMU_DR_W-1:0] drx;
		logic signed [`TMU_DR_W-1:0] dry;
	} vdiv_ops_t;

	// one divided edge with its sign carried along
	typedef struct packed {
		logic positive;
		logic [`TMU_DIFF_W-1:0] quotient;
		logic [`TMU_SQH_W-1:0] remainder;
	} quot_t;

	// result handed to the vertical interpolation stages
	typedef struct packed {
		point_t a;
		point_t b;
		quot_t cx;
		quot_t cy;
		quot_t dx;
		quot_t dy;
		logic signed [`TMU_DR_W-1:0] drx;
		logic signed [`TMU_DR_W-1:0] dry;
	} vdiv_out_t;

endpackage

`default_nettype wire

/* verilog/tmu_defs.svh */
// width definitions for the texture mapping vertical division front end
// coordinates and resolutions are signed, magnitudes and divisors are unsigned
`ifndef TMU_DEFS_SVH
`define TMU_DEFS_SVH

// signed vertex coordinate in fixed point
`define TMU_COORD_W 18

// magnitude of an edge difference, the quotient has the same width
`define TMU_DIFF_W 17

// signed destination resolution drx and dry
`define TMU_DR_W 12

// destination square height used as the divisor
`define TMU_SQH_W 11

`endif
